// File: axi_lite_demux.sv
////////////////////////////////////////
// One transaction open at a time, write wins
// Unmapped addresses get DECERR from inside
////////////////////////////////////////
`timescale 1ns/1ps

module axi_lite_demux #(
  parameter cluster_pkg::addr_t cluster_base_addr = 32'h1000_0000,
  parameter int unsigned        tcdm_words        = 256
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  cluster_pkg::axil_req_t  in_req,
  output cluster_pkg::axil_resp_t in_resp,
  output cluster_pkg::axil_req_t  mem_req,
  input  cluster_pkg::axil_resp_t mem_resp,
  output cluster_pkg::axil_req_t  periph_req,
  input  cluster_pkg::axil_resp_t periph_resp
);

  localparam cluster_pkg::addr_t periph_base =
    cluster_base_addr + cluster_pkg::addr_t'(4 * tcdm_words);
  localparam cluster_pkg::addr_t periph_end =
    periph_base + cluster_pkg::addr_t'(cluster_pkg::periph_window_bytes);

  typedef enum logic [1:0] {tgt_mem, tgt_periph, tgt_err} tgt_e;
  typedef enum logic [1:0] {err_idle, err_wdata, err_bresp, err_rresp} err_state_e;

  logic                    open_q;
  logic                    write_q;
  tgt_e                    tgt_q;
  tgt_e                    dec_tgt;
  tgt_e                    cur_tgt;
  cluster_pkg::addr_t      dec_addr;
  logic [2:0]              sel_new;
  logic [2:0]              sel_wr;
  logic [2:0]              sel_rd;
  cluster_pkg::axil_req_t  err_req;
  cluster_pkg::axil_resp_t err_resp;
  cluster_pkg::axil_resp_t sel_resp;
  err_state_e              err_state_q;
  logic                    aw_xfer;
  logic                    ar_xfer;
  logic                    b_xfer;
  logic                    r_xfer;

  function automatic tgt_e decode(input cluster_pkg::addr_t addr);
    if (addr >= cluster_base_addr && addr < periph_base) begin
      return tgt_mem;
    end
    if (addr >= periph_base && addr < periph_end) begin
      return tgt_periph;
    end
    return tgt_err;
  endfunction

  // Gate the channels toward one subordinate and rebase its addresses
  function automatic cluster_pkg::axil_req_t route_req(
    input cluster_pkg::axil_req_t req,
    input logic                   new_sel,
    input logic                   wr_sel,
    input logic                   rd_sel,
    input cluster_pkg::addr_t     base
  );
    cluster_pkg::axil_req_t fwd;
    fwd          = req;
    fwd.aw_addr  = req.aw_addr - base;
    fwd.ar_addr  = req.ar_addr - base;
    fwd.aw_valid = req.aw_valid & new_sel;
    fwd.ar_valid = req.ar_valid & ~req.aw_valid & new_sel;
    fwd.w_valid  = req.w_valid & wr_sel;
    fwd.b_ready  = req.b_ready & wr_sel;
    fwd.r_ready  = req.r_ready & rd_sel;
    return fwd;
  endfunction

  ////////////////////////////////////////
  // Decode and steering
  ////////////////////////////////////////

  assign dec_addr = in_req.aw_valid ? in_req.aw_addr : in_req.ar_addr;
  assign dec_tgt  = decode(dec_addr);
  assign cur_tgt  = open_q ? tgt_q : dec_tgt;

  always_comb begin
    for (int t = 0; t < 3; t++) begin
      sel_new[t] = !open_q && (dec_tgt == tgt_e'(t));
      sel_wr[t]  = open_q && write_q && (tgt_q == tgt_e'(t));
      sel_rd[t]  = open_q && !write_q && (tgt_q == tgt_e'(t));
    end
  end

  assign mem_req = route_req(in_req, sel_new[tgt_mem], sel_wr[tgt_mem], sel_rd[tgt_mem],
                             cluster_base_addr);
  assign periph_req = route_req(in_req, sel_new[tgt_periph], sel_wr[tgt_periph],
                                sel_rd[tgt_periph], periph_base);
  assign err_req = route_req(in_req, sel_new[tgt_err], sel_wr[tgt_err], sel_rd[tgt_err], '0);

  always_comb begin
    case (cur_tgt)
      tgt_mem:    sel_resp = mem_resp;
      tgt_periph: sel_resp = periph_resp;
      default:    sel_resp = err_resp;
    endcase
    in_resp          = sel_resp;
    in_resp.aw_ready = !open_q && sel_resp.aw_ready;
    in_resp.ar_ready = !open_q && !in_req.aw_valid && sel_resp.ar_ready;
    in_resp.w_ready  = open_q && write_q && sel_resp.w_ready;
    in_resp.b_valid  = open_q && write_q && sel_resp.b_valid;
    in_resp.r_valid  = open_q && !write_q && sel_resp.r_valid;
  end

  assign aw_xfer = in_req.aw_valid && in_resp.aw_ready;
  assign ar_xfer = in_req.ar_valid && in_resp.ar_ready;
  assign b_xfer  = in_req.b_ready && in_resp.b_valid;
  assign r_xfer  = in_req.r_ready && in_resp.r_valid;

  // Target held until the closing B or R
  always_ff @(posedge clk) begin
    if (rst_n) begin
      open_q  <= 1'b0;
      write_q <= 1'b0;
      tgt_q   <= tgt_err;
    end else if (!open_q) begin
      if (aw_xfer) begin
        open_q  <= 1'b1;
        write_q <= 1'b1;
        tgt_q   <= dec_tgt;
      end else if (ar_xfer) begin
        open_q  <= 1'b1;
        write_q <= 1'b0;
        tgt_q   <= dec_tgt;
      end
    end else if (b_xfer || r_xfer) begin
      open_q <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // Decode-error responder
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_n) begin
      err_state_q <= err_idle;
    end else begin
      case (err_state_q)
        err_idle: begin
          if (err_req.aw_valid) begin
            err_state_q <= err_wdata;
          end else if (err_req.ar_valid) begin
            err_state_q <= err_rresp;
          end
        end
        // Write data is swallowed
        err_wdata: if (err_req.w_valid) err_state_q <= err_bresp;
        err_bresp: if (err_req.b_ready) err_state_q <= err_idle;
        default:   if (err_req.r_ready) err_state_q <= err_idle;
      endcase
    end
  end

  always_comb begin
    err_resp          = '0;
    err_resp.aw_ready = (err_state_q == err_idle);
    err_resp.ar_ready = (err_state_q == err_idle) && !err_req.aw_valid;
    err_resp.w_ready  = (err_state_q == err_wdata);
    err_resp.b_valid  = (err_state_q == err_bresp);
    err_resp.b_resp   = cluster_pkg::resp_decerr;
    err_resp.r_valid  = (err_state_q == err_rresp);
    err_resp.r_resp   = cluster_pkg::resp_decerr;
  end

endmodule

// File: cluster_ctrl_top.f
+incdir+.
cluster_pkg.sv
axi_lite_demux.sv
tcdm_sram.sv
periph_regs.sv
cluster_ctrl_top.sv
tb_cluster_ctrl.sv

// File: cluster_ctrl_top.sv
////////////////////////////////////////
// TCDM at cluster_base_addr, peripherals follow
////////////////////////////////////////
`timescale 1ns/1ps

module cluster_ctrl_top #(
  parameter int unsigned        nr_cores          = 8,
  parameter cluster_pkg::addr_t cluster_base_addr = 32'h1000_0000,
  parameter int unsigned        tcdm_words        = 256
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  cluster_pkg::axil_req_t  narrow_req,
  output cluster_pkg::axil_resp_t narrow_resp,
  output logic [nr_cores-1:0]     msip,
  output cluster_pkg::addr_t      boot_addr
);

  cluster_pkg::axil_req_t  mem_req;
  cluster_pkg::axil_resp_t mem_resp;
  cluster_pkg::axil_req_t  periph_req;
  cluster_pkg::axil_resp_t periph_resp;

  axi_lite_demux #(
    .cluster_base_addr (cluster_base_addr),
    .tcdm_words        (tcdm_words)
  ) u_demux (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_req      (narrow_req),
    .in_resp     (narrow_resp),
    .mem_req     (mem_req),
    .mem_resp    (mem_resp),
    .periph_req  (periph_req),
    .periph_resp (periph_resp)
  );

  tcdm_sram #(
    .tcdm_words (tcdm_words)
  ) u_tcdm (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (mem_req),
    .resp  (mem_resp)
  );

  periph_regs #(
    .nr_cores (nr_cores)
  ) u_periph (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (periph_req),
    .resp      (periph_resp),
    .msip      (msip),
    .boot_addr (boot_addr)
  );

endmodule

// File: cluster_pkg.sv
////////////////////////////////////////
// Narrow AXI4-Lite types for the cluster control port
// No bursts, IDs or user bits
////////////////////////////////////////

package cluster_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  parameter int unsigned addr_width = 32;
  parameter int unsigned data_width = 32;
  parameter int unsigned strb_width = data_width / 8;

  typedef logic [addr_width-1:0] addr_t;
  typedef logic [data_width-1:0] data_t;
  typedef logic [strb_width-1:0] strb_t;
  typedef logic [1:0]            resp_t;

  // AXI response codes
  localparam resp_t resp_okay   = 2'b00;
  localparam resp_t resp_slverr = 2'b10;
  localparam resp_t resp_decerr = 2'b11;

  ////////////////////////////////////////
  // Peripheral map
  ////////////////////////////////////////

  localparam addr_t scratch_0_offset      = 32'h0000_0000;
  localparam addr_t scratch_1_offset      = 32'h0000_0004;
  localparam addr_t scratch_2_offset      = 32'h0000_0008;
  localparam addr_t scratch_3_offset      = 32'h0000_000C;
  localparam addr_t cl_clint_set_offset   = 32'h0000_0010;
  localparam addr_t cl_clint_clear_offset = 32'h0000_0014;

  // Size of the window after the TCDM
  localparam int unsigned periph_window_bytes = 4096;

  ////////////////////////////////////////
  // Channel bundles
  ////////////////////////////////////////

  // Manager to subordinate
  typedef struct packed {
    addr_t aw_addr;
    logic  aw_valid;
    data_t w_data;
    strb_t w_strb;
    logic  w_valid;
    logic  b_ready;
    addr_t ar_addr;
    logic  ar_valid;
    logic  r_ready;
  } axil_req_t;

  // Subordinate to manager
  typedef struct packed {
    logic  aw_ready;
    logic  w_ready;
    resp_t b_resp;
    logic  b_valid;
    logic  ar_ready;
    data_t r_data;
    resp_t r_resp;
    logic  r_valid;
  } axil_resp_t;

  // Byte lanes of wdata replace old where the strobe is set
  function automatic data_t strb_merge(input data_t old, input data_t wdata, input strb_t strb);
    data_t res;
    res = old;
    for (int b = 0; b < strb_width; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return res;
  endfunction

endpackage

// File: periph_regs.sv
////////////////////////////////////////
// CLINT writes ignore strobes, nr_cores up to 32
// Unused offsets answer SLVERR
////////////////////////////////////////
`timescale 1ns/1ps

module periph_regs #(
  parameter int unsigned nr_cores = 8
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  cluster_pkg::axil_req_t  req,
  output cluster_pkg::axil_resp_t resp,
  output logic [nr_cores-1:0]     msip,
  output cluster_pkg::addr_t      boot_addr
);

  typedef enum logic [1:0] {st_idle, st_wdata, st_bresp, st_rresp} state_e;

  state_e              state_q;
  cluster_pkg::data_t  scratch_q [4];
  logic [nr_cores-1:0] clint_q;
  cluster_pkg::addr_t  waddr_q;
  cluster_pkg::resp_t  wr_resp;
  cluster_pkg::resp_t  bresp_q;
  cluster_pkg::data_t  rd_data;
  cluster_pkg::resp_t  rd_resp;
  cluster_pkg::data_t  rdata_q;
  cluster_pkg::resp_t  rresp_q;
  logic                aw_xfer;
  logic                w_xfer;
  logic                ar_xfer;

  assign aw_xfer = req.aw_valid && resp.aw_ready;
  assign w_xfer  = req.w_valid && resp.w_ready;
  assign ar_xfer = req.ar_valid && resp.ar_ready;

  ////////////////////////////////////////
  // Handshake FSM
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= st_idle;
    end else begin
      case (state_q)
        st_idle: begin
          if (aw_xfer) begin
            state_q <= st_wdata;
          end else if (ar_xfer) begin
            state_q <= st_rresp;
          end
        end
        st_wdata: if (w_xfer) state_q <= st_bresp;
        st_bresp: if (req.b_ready) state_q <= st_idle;
        default:  if (req.r_ready) state_q <= st_idle;
      endcase
    end
  end

  ////////////////////////////////////////
  // Register file
  ////////////////////////////////////////

  // Write offset valid?
  always_comb begin
    case (waddr_q)
      cluster_pkg::scratch_0_offset,
      cluster_pkg::scratch_1_offset,
      cluster_pkg::scratch_2_offset,
      cluster_pkg::scratch_3_offset,
      cluster_pkg::cl_clint_set_offset,
      cluster_pkg::cl_clint_clear_offset: wr_resp = cluster_pkg::resp_okay;
      default:                            wr_resp = cluster_pkg::resp_slverr;
    endcase
  end

  // Takes effect on the W edge, visible the cycle after
  always_ff @(posedge clk) begin
    if (rst_n) begin
      scratch_q <= '{default: '0};
      clint_q   <= '0;
    end else if (w_xfer) begin
      case (waddr_q)
        cluster_pkg::scratch_0_offset:
          scratch_q[0] <= cluster_pkg::strb_merge(scratch_q[0], req.w_data, req.w_strb);
        cluster_pkg::scratch_1_offset:
          scratch_q[1] <= cluster_pkg::strb_merge(scratch_q[1], req.w_data, req.w_strb);
        cluster_pkg::scratch_2_offset:
          scratch_q[2] <= cluster_pkg::strb_merge(scratch_q[2], req.w_data, req.w_strb);
        cluster_pkg::scratch_3_offset:
          scratch_q[3] <= cluster_pkg::strb_merge(scratch_q[3], req.w_data, req.w_strb);
        cluster_pkg::cl_clint_set_offset:   clint_q <= clint_q | req.w_data[nr_cores-1:0];
        cluster_pkg::cl_clint_clear_offset: clint_q <= clint_q & ~req.w_data[nr_cores-1:0];
        default: ;
      endcase
    end
  end

  // Read mux on the AR address
  always_comb begin
    rd_data = '0;
    rd_resp = cluster_pkg::resp_okay;
    case (req.ar_addr)
      cluster_pkg::scratch_0_offset:      rd_data = scratch_q[0];
      cluster_pkg::scratch_1_offset:      rd_data = scratch_q[1];
      cluster_pkg::scratch_2_offset:      rd_data = scratch_q[2];
      cluster_pkg::scratch_3_offset:      rd_data = scratch_q[3];
      cluster_pkg::cl_clint_set_offset,
      cluster_pkg::cl_clint_clear_offset: rd_data = cluster_pkg::data_t'(clint_q);
      default:                            rd_resp = cluster_pkg::resp_slverr;
    endcase
  end

  always_ff @(posedge clk) begin
    if (aw_xfer) begin
      waddr_q <= req.aw_addr;
    end
    if (w_xfer) begin
      bresp_q <= wr_resp;
    end
    if (ar_xfer) begin
      rdata_q <= rd_data;
      rresp_q <= rd_resp;
    end
  end

  always_comb begin
    resp          = '0;
    resp.aw_ready = (state_q == st_idle);
    resp.ar_ready = (state_q == st_idle) && !req.aw_valid;
    resp.w_ready  = (state_q == st_wdata);
    resp.b_valid  = (state_q == st_bresp);
    resp.b_resp   = bresp_q;
    resp.r_valid  = (state_q == st_rresp);
    resp.r_data   = rdata_q;
    resp.r_resp   = rresp_q;
  end

  // Scratch 1 is the boot entry point
  assign boot_addr = cluster_pkg::addr_t'(scratch_q[1]);
  assign msip      = clint_q;

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the cluster control testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f cluster_ctrl_top.f --top-module tb_cluster_ctrl -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
  echo "Simulation failed"
  exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation passed"

// File: tb_axi_lite_tasks.svh
////////////////////////////////////////
// Included inside the testbench module, uses its clk, narrow port and nr_cores
// One transaction at a time, inputs change on the falling edge
////////////////////////////////////////
`ifndef tb_axi_lite_tasks_svh
`define tb_axi_lite_tasks_svh

// Channel selectors for the handshake wait
localparam int ch_aw = 0;
localparam int ch_w  = 1;
localparam int ch_b  = 2;
localparam int ch_ar = 3;
localparam int ch_r  = 4;

// Galois LFSR, one step per bit taken
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  if (s[0]) begin
    return (s >> 1) ^ 32'h8020_0003;
  end
  return s >> 1;
endfunction

function automatic logic chan_hit(input int ch, input cluster_pkg::axil_resp_t snap);
  case (ch)
    ch_aw:   return snap.aw_ready;
    ch_w:    return snap.w_ready;
    ch_b:    return snap.b_valid;
    ch_ar:   return snap.ar_ready;
    default: return snap.r_valid;
  endcase
endfunction

// Samples mid low phase, returns on the rising edge that completes the transfer
task automatic await_handshake(input int ch, output int waits,
                               output cluster_pkg::axil_resp_t snap);
  logic hit;
  waits = 0;
  #(clk_period / 4);
  snap = narrow_resp;
  hit  = chan_hit(ch, snap);
  while (!hit) begin
    @(negedge clk);
    #(clk_period / 4);
    snap = narrow_resp;
    hit  = chan_hit(ch, snap);
    waits++;
  end
  @(posedge clk);
endtask

////////////////////////////////////////
// Write as AW, W, B
////////////////////////////////////////

task automatic axil_write(input cluster_pkg::addr_t addr, input cluster_pkg::data_t data,
                          input cluster_pkg::strb_t strb, output cluster_pkg::resp_t resp,
                          output int b_cycles, output logic [nr_cores-1:0] msip_obs,
                          output cluster_pkg::addr_t boot_obs);
  int                      waits;
  cluster_pkg::axil_resp_t snap;
  @(negedge clk);
  narrow_req.b_ready  = 1'b0;
  narrow_req.r_ready  = 1'b0;
  narrow_req.aw_addr  = addr;
  narrow_req.aw_valid = 1'b1;
  await_handshake(ch_aw, waits, snap);
  @(negedge clk);
  narrow_req.aw_valid = 1'b0;
  narrow_req.w_data   = data;
  narrow_req.w_strb   = strb;
  narrow_req.w_valid  = 1'b1;
  await_handshake(ch_w, waits, snap);
  @(negedge clk);
  narrow_req.w_valid = 1'b0;
  narrow_req.b_ready = 1'b1;
  // One cycle after the W transfer
  #1;
  msip_obs = msip;
  boot_obs = boot_addr;
  await_handshake(ch_b, waits, snap);
  resp     = snap.b_resp;
  b_cycles = waits + 1;
endtask

////////////////////////////////////////
// Read as AR, R with optional r_ready hold
////////////////////////////////////////

task automatic axil_read(input cluster_pkg::addr_t addr, input int hold,
                         output cluster_pkg::data_t data, output cluster_pkg::resp_t resp,
                         output int r_cycles, output int unstable,
                         output logic [nr_cores-1:0] msip_obs,
                         output cluster_pkg::addr_t boot_obs);
  int                      waits;
  cluster_pkg::axil_resp_t snap;
  cluster_pkg::data_t      first;
  unstable = 0;
  @(negedge clk);
  narrow_req.b_ready  = 1'b0;
  narrow_req.r_ready  = 1'b0;
  narrow_req.ar_addr  = addr;
  narrow_req.ar_valid = 1'b1;
  await_handshake(ch_ar, waits, snap);
  @(negedge clk);
  narrow_req.ar_valid = 1'b0;
  narrow_req.r_ready  = (hold == 0);
  #1;
  msip_obs = msip;
  boot_obs = boot_addr;
  first    = narrow_resp.r_data;
  // Response must sit still while r_ready is low
  for (int k = 0; k < hold; k++) begin
    #(clk_period / 4);
    if (!narrow_resp.r_valid || narrow_resp.r_data != first || narrow_resp.aw_ready) begin
      unstable++;
    end
    @(negedge clk);
  end
  narrow_req.r_ready = 1'b1;
  await_handshake(ch_r, waits, snap);
  data     = snap.r_data;
  resp     = snap.r_resp;
  r_cycles = hold + waits + 1;
endtask

`endif

// File: tb_cluster_ctrl.sv
////////////////////////////////////////
// Default DUT parameters, 8 cores, 256-word TCDM
// Expected values come from a model filled while the table is built
////////////////////////////////////////
`timescale 1ns/1ps

module tb_cluster_ctrl;

  localparam int                 clk_period   = 100;
  localparam int unsigned        nr_cores     = 8;
  localparam int unsigned        tcdm_words   = 256;
  localparam cluster_pkg::addr_t cluster_base = 32'h1000_0000;
  localparam cluster_pkg::addr_t periph_base  = cluster_base + 32'(4 * tcdm_words);
  localparam cluster_pkg::addr_t periph_end   = periph_base + 32'h0000_1000;

  typedef enum {op_write, op_read, op_hold} op_e;

  typedef struct {
    string               name;
    op_e                 op;
    cluster_pkg::addr_t  addr;
    cluster_pkg::data_t  data;
    cluster_pkg::strb_t  strb;
    int                  hold;
    cluster_pkg::resp_t  exp_resp;
    cluster_pkg::data_t  exp_data;
    logic [nr_cores-1:0] exp_msip;
    cluster_pkg::addr_t  exp_boot;
  } row_t;

  logic                    clk;
  logic                    rst_n;
  cluster_pkg::axil_req_t  narrow_req;
  cluster_pkg::axil_resp_t narrow_resp;
  logic [nr_cores-1:0]     msip;
  cluster_pkg::addr_t      boot_addr;

  row_t                rows [$];
  bit                  table_ready;
  logic [31:0]         lfsr_state;
  int                  test_errs;
  int                  passed;
  int                  failed;
  cluster_pkg::data_t  tcdm_model [int unsigned];
  cluster_pkg::data_t  scratch_model [4];
  logic [nr_cores-1:0] clint_model;

  `include "tb_axi_lite_tasks.svh"

  cluster_ctrl_top #(
    .nr_cores          (nr_cores),
    .cluster_base_addr (cluster_base),
    .tcdm_words        (tcdm_words)
  ) DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .narrow_req  (narrow_req),
    .narrow_resp (narrow_resp),
    .msip        (msip),
    .boot_addr   (boot_addr)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  ////////////////////////////////////////
  // Reference model and table
  ////////////////////////////////////////

  function automatic cluster_pkg::data_t rand_word();
    cluster_pkg::data_t w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      w          = {lfsr_state[0], w[31:1]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return w;
  endfunction

  function automatic cluster_pkg::data_t merge_bytes(input cluster_pkg::data_t old,
                                                     input cluster_pkg::data_t wdata,
                                                     input cluster_pkg::strb_t strb);
    cluster_pkg::data_t res;
    for (int b = 0; b < 4; b++) begin
      res[8*b +: 8] = strb[b] ? wdata[8*b +: 8] : old[8*b +: 8];
    end
    return res;
  endfunction

  function automatic void add_row(input string name, input op_e op,
                                  input cluster_pkg::addr_t addr, input cluster_pkg::data_t data,
                                  input cluster_pkg::strb_t strb, input int hold);
    row_t               r;
    int unsigned        idx;
    cluster_pkg::addr_t off;
    cluster_pkg::data_t old;
    r.name     = name;
    r.op       = op;
    r.addr     = addr;
    r.data     = data;
    r.strb     = strb;
    r.hold     = hold;
    r.exp_resp = cluster_pkg::resp_okay;
    r.exp_data = '0;
    if (addr >= cluster_base && addr < periph_base) begin
      idx = ((addr - cluster_base) >> 2) % tcdm_words;
      old = tcdm_model.exists(idx) ? tcdm_model[idx] : '0;
      if (op == op_write) begin
        tcdm_model[idx] = merge_bytes(old, data, strb);
      end else begin
        r.exp_data = old;
      end
    end else if (addr >= periph_base && addr < periph_end) begin
      off = addr - periph_base;
      case (off)
        cluster_pkg::scratch_0_offset, cluster_pkg::scratch_1_offset,
        cluster_pkg::scratch_2_offset, cluster_pkg::scratch_3_offset: begin
          if (op == op_write) begin
            scratch_model[off[3:2]] = merge_bytes(scratch_model[off[3:2]], data, strb);
          end else begin
            r.exp_data = scratch_model[off[3:2]];
          end
        end
        cluster_pkg::cl_clint_set_offset, cluster_pkg::cl_clint_clear_offset: begin
          if (op != op_write) begin
            r.exp_data = cluster_pkg::data_t'(clint_model);
          end else if (off == cluster_pkg::cl_clint_set_offset) begin
            clint_model = clint_model | data[nr_cores-1:0];
          end else begin
            clint_model = clint_model & ~data[nr_cores-1:0];
          end
        end
        default: r.exp_resp = cluster_pkg::resp_slverr;
      endcase
    end else begin
      r.exp_resp = cluster_pkg::resp_decerr;
    end
    r.exp_msip = clint_model;
    r.exp_boot = scratch_model[1];
    rows.push_back(r);
  endfunction

  function automatic void build_table();
    cluster_pkg::addr_t pb;
    pb = periph_base;
    // TCDM with random words, one partial strobe
    add_row("tcdm_wr_0", op_write, cluster_base + 32'h000, rand_word(), 4'hF, 0);
    add_row("tcdm_wr_5", op_write, cluster_base + 32'h014, rand_word(), 4'hF, 0);
    add_row("tcdm_wr_100", op_write, cluster_base + 32'h190, rand_word(), 4'hF, 0);
    add_row("tcdm_wr_255", op_write, cluster_base + 32'h3FC, rand_word(), 4'hF, 0);
    add_row("tcdm_wr_5_part", op_write, cluster_base + 32'h014, rand_word(), 4'b0101, 0);
    add_row("tcdm_rd_0", op_read, cluster_base + 32'h000, '0, '0, 0);
    add_row("tcdm_rd_5", op_read, cluster_base + 32'h014, '0, '0, 0);
    add_row("tcdm_rd_100", op_read, cluster_base + 32'h190, '0, '0, 0);
    add_row("tcdm_rd_255", op_read, cluster_base + 32'h3FC, '0, '0, 0);
    // Entry point and scratch
    add_row("boot_wr", op_write, pb + cluster_pkg::scratch_1_offset, 32'h8000_1000, 4'hF, 0);
    add_row("scratch0_wr", op_write, pb + cluster_pkg::scratch_0_offset, 32'h1357_9BDF, 4'hF, 0);
    add_row("scratch2_wr", op_write, pb + cluster_pkg::scratch_2_offset, 32'h2468_ACE0, 4'hF, 0);
    add_row("scratch3_wr", op_write, pb + cluster_pkg::scratch_3_offset, 32'hA5A5_5A5A, 4'hC, 0);
    add_row("scratch0_rd", op_read, pb + cluster_pkg::scratch_0_offset, '0, '0, 0);
    add_row("scratch1_rd", op_read, pb + cluster_pkg::scratch_1_offset, '0, '0, 0);
    add_row("scratch2_rd", op_read, pb + cluster_pkg::scratch_2_offset, '0, '0, 0);
    add_row("scratch3_rd", op_read, pb + cluster_pkg::scratch_3_offset, '0, '0, 0);
    // Cluster CLINT
    add_row("clint_set", op_write, pb + cluster_pkg::cl_clint_set_offset, '1, 4'hF, 0);
    add_row("clint_clear", op_write, pb + cluster_pkg::cl_clint_clear_offset,
            32'h0000_00A5, 4'hF, 0);
    add_row("clint_rd_set", op_read, pb + cluster_pkg::cl_clint_set_offset, '0, '0, 0);
    add_row("clint_rd_clear", op_read, pb + cluster_pkg::cl_clint_clear_offset, '0, '0, 0);
    // Decode and subordinate errors
    add_row("decerr_wr", op_write, 32'h2000_0000, 32'h1111_2222, 4'hF, 0);
    add_row("decerr_rd", op_read, 32'h2000_0000, '0, '0, 0);
    add_row("decerr_rd_low", op_read, cluster_base - 32'h4, '0, '0, 0);
    add_row("slverr_wr", op_write, pb + 32'h40, '1, 4'hF, 0);
    add_row("slverr_rd", op_read, pb + 32'h40, '0, '0, 0);
    add_row("scratch0_after", op_read, pb + cluster_pkg::scratch_0_offset, '0, '0, 0);
    add_row("scratch2_after", op_read, pb + cluster_pkg::scratch_2_offset, '0, '0, 0);
    // Back-pressure on R
    add_row("hold_tcdm_100", op_hold, cluster_base + 32'h190, '0, '0, 4);
    add_row("hold_scratch1", op_hold, pb + cluster_pkg::scratch_1_offset, '0, '0, 3);
  endfunction

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_resp(input string name, input cluster_pkg::resp_t exp,
                            input cluster_pkg::resp_t act);
    if (act !== exp) begin
      $display("FAIL %s resp: expected %0d, actual %0d", name, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_data(input string name, input cluster_pkg::data_t exp,
                            input cluster_pkg::data_t act);
    if (act !== exp) begin
      $display("FAIL %s data: expected %08h, actual %08h", name, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_msip(input string name, input logic [nr_cores-1:0] exp,
                            input logic [nr_cores-1:0] act);
    if (act !== exp) begin
      $display("FAIL %s msip: expected %02h, actual %02h", name, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_addr(input string name, input cluster_pkg::addr_t exp,
                            input cluster_pkg::addr_t act);
    if (act !== exp) begin
      $display("FAIL %s boot_addr: expected %08h, actual %08h", name, exp, act);
      test_errs++;
    end
  endtask

  task automatic check_cycles(input string name, input string what, input int exp,
                              input int act);
    if (act != exp) begin
      $display("FAIL %s %s cycles: expected %0d, actual %0d", name, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic finish_test(input string name);
    if (test_errs == 0) begin
      $display("test %s: ok", name);
      passed++;
    end else begin
      $display("test %s: %0d errors", name, test_errs);
      failed++;
    end
  endtask

  task automatic run_row(input row_t r);
    cluster_pkg::data_t  rdata;
    cluster_pkg::resp_t  resp;
    int                  cyc;
    int                  unstable;
    logic [nr_cores-1:0] msip_obs;
    cluster_pkg::addr_t  boot_obs;
    test_errs = 0;
    if (r.op == op_write) begin
      axil_write(r.addr, r.data, r.strb, resp, cyc, msip_obs, boot_obs);
      check_cycles(r.name, "W to B", 1, cyc);
    end else begin
      axil_read(r.addr, r.hold, rdata, resp, cyc, unstable, msip_obs, boot_obs);
      check_data(r.name, r.exp_data, rdata);
      check_cycles(r.name, "AR to R", 1 + r.hold, cyc);
      if (unstable != 0) begin
        $display("%s: read response moved or aw_ready rose while r_ready was low", r.name);
        test_errs++;
      end
    end
    check_resp(r.name, r.exp_resp, resp);
    check_msip(r.name, r.exp_msip, msip_obs);
    check_addr(r.name, r.exp_boot, boot_obs);
    finish_test(r.name);
  endtask

  ////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////

  initial begin
    rst_n         = 1'b1;
    narrow_req    = '0;
    lfsr_state    = 32'h32c9c00f;
    scratch_model = '{default: '0};
    clint_model   = '0;
    passed        = 0;
    failed        = 0;
    build_table();
    table_ready = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b0;
    #1;
    test_errs = 0;
    check_msip("reset_state", '0, msip);
    check_addr("reset_state", '0, boot_addr);
    finish_test("reset_state");
    foreach (rows[i]) begin
      run_row(rows[i]);
    end
    $display("%0d tests, %0d passed, %0d failed", passed + failed, passed, failed);
    if (failed == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    wait (table_ready);
    repeat (rows.size() * 20 + 50) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d cycles", rows.size() * 20 + 50);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

// File: tcdm_sram.sv
////////////////////////////////////////
// Depth must be a power of two, offsets wrap
// Always answers OKAY
////////////////////////////////////////
`timescale 1ns/1ps

module tcdm_sram #(
  parameter int unsigned tcdm_words = 256
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  cluster_pkg::axil_req_t  req,
  output cluster_pkg::axil_resp_t resp
);

  localparam int unsigned idx_width = $clog2(tcdm_words);

  typedef enum logic [1:0] {st_idle, st_wdata, st_bresp, st_rresp} state_e;

  state_e                 state_q;
  cluster_pkg::data_t     mem [tcdm_words];
  logic [idx_width-1:0]   widx_q;
  cluster_pkg::data_t     rdata_q;
  logic                   aw_xfer;
  logic                   w_xfer;
  logic                   ar_xfer;

  assign aw_xfer = req.aw_valid && resp.aw_ready;
  assign w_xfer  = req.w_valid && resp.w_ready;
  assign ar_xfer = req.ar_valid && resp.ar_ready;

  ////////////////////////////////////////
  // Handshake FSM
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= st_idle;
    end else begin
      case (state_q)
        st_idle: begin
          if (aw_xfer) begin
            state_q <= st_wdata;
          end else if (ar_xfer) begin
            state_q <= st_rresp;
          end
        end
        st_wdata: if (w_xfer) state_q <= st_bresp;
        st_bresp: if (req.b_ready) state_q <= st_idle;
        default:  if (req.r_ready) state_q <= st_idle;
      endcase
    end
  end

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  // Word index drops the byte offset and any bits above the depth
  always_ff @(posedge clk) begin
    if (aw_xfer) begin
      widx_q <= req.aw_addr[idx_width+1:2];
    end
    if (w_xfer) begin
      mem[widx_q] <= cluster_pkg::strb_merge(mem[widx_q], req.w_data, req.w_strb);
    end
    if (ar_xfer) begin
      rdata_q <= mem[req.ar_addr[idx_width+1:2]];
    end
  end

  always_comb begin
    resp          = '0;
    resp.aw_ready = (state_q == st_idle);
    resp.ar_ready = (state_q == st_idle) && !req.aw_valid;
    resp.w_ready  = (state_q == st_wdata);
    resp.b_valid  = (state_q == st_bresp);
    resp.b_resp   = cluster_pkg::resp_okay;
    resp.r_valid  = (state_q == st_rresp);
    resp.r_data   = rdata_q;
    resp.r_resp   = cluster_pkg::resp_okay;
  end

endmodule
